// ==== hw/sifhHist_macros.svh ====
`ifndef SIFHHIST_MACROS_SVH
`define SIFHHIST_MACROS_SVH

// TDC code width
`define NP 10

// bin index width, top bits of the code, 16 bins
`define NB 4

// saturating count per bin
`define CNT_W 8

// codes at or above this value fall outside the window
`define TIME_WINDOW 800

// accepted events that end one acquisition
`define ACQ_EVENTS 300

`endif

// ==== hw/histDataPkg.sv ====
`include "sifhHist_macros.svh"

package histDataPkg;

    // one raw TDC code
    typedef logic [`NP-1:0] timeCode_t;

    // histogram address, taken from the code MSBs
    typedef logic [`NB-1:0] binIdx_t;

    // bin content, saturates at all ones
    typedef logic [`CNT_W-1:0] binCount_t;

    // accepted events and rejects per run
    typedef logic [15:0] evCount_t;

endpackage

// ==== hw/histCtrlPkg.sv ====
package histCtrlPkg;

    // acquisition sequencing
    typedef enum logic [2:0] {
        ACC_IDLE,
        ACC_CLEAR,
        ACC_RUN,
        ACC_DRAIN,
        ACC_READOUT
    } accState_t;

    // histogram sweep and peak report
    typedef enum logic [1:0] {
        RD_IDLE,
        RD_SWEEP,
        RD_PEAK
    } rdState_t;

endpackage

// ==== hw/photonCapture.sv ====
`timescale 1ns/1ps
`include "sifhHist_macros.svh"

module photonCapture (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  acquiring,
    input  logic                  dataValid,
    input  histDataPkg::timeCode_t data,
    output logic                  evValid,
    output histDataPkg::binIdx_t  evBin,
    output histDataPkg::evCount_t rejectCount,
    input  logic                  acqStart
);

    logic inWindow;
    logic accept;
    logic reject;

    assign inWindow = data < histDataPkg::timeCode_t'(`TIME_WINDOW);
    assign accept = dataValid && acquiring && inWindow;
    assign reject = dataValid && acquiring && !inWindow;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            evValid <= 1'b0;
        end else begin
            evValid <= accept; // one cycle behind the input
        end
    end

    // bin is the top bits of the code
    always_ff @(posedge clk) begin
        if (dataValid) begin
            evBin <= data[`NP-1 -: `NB];
        end
    end

    // a start arriving mid-run is not taken by the accumulator
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            rejectCount <= '0;
        end else if (acqStart && !acquiring) begin
            rejectCount <= '0;
        end else if (reject) begin
            rejectCount <= rejectCount + 1'b1;
        end
    end

    // accepted bins stay below the window edge
    aEvGated: assert property (@(posedge clk) disable iff (!res)
        evValid |-> $past(acquiring)
            && (evBin <= histDataPkg::binIdx_t'((`TIME_WINDOW - 1) >> (`NP - `NB))));

endmodule

// ==== hw/histRam.sv ====
`timescale 1ns/1ps
`include "sifhHist_macros.svh"

module histRam (
    input  logic                   clk,
    input  logic                   wrEn,
    input  histDataPkg::binIdx_t   wrAddr,
    input  histDataPkg::binCount_t wrData,
    input  histDataPkg::binIdx_t   rdAddrA,
    output histDataPkg::binCount_t rdDataA,
    input  logic                   rdEnB,
    input  histDataPkg::binIdx_t   rdAddrB,
    output histDataPkg::binCount_t rdDataB
);

    histDataPkg::binCount_t mem [0:(1 << `NB) - 1];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // port A, accumulator side
    always_ff @(posedge clk) begin
        rdDataA <= mem[rdAddrA]; // old data on a same-cycle write
    end

    // port B, readout side
    always_ff @(posedge clk) begin
        if (rdEnB) begin
            rdDataB <= mem[rdAddrB];
        end
    end

endmodule

// ==== hw/histAccumulator.sv ====
`timescale 1ns/1ps
`include "sifhHist_macros.svh"

module histAccumulator (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   acqStart,
    input  logic                   evValid,
    input  histDataPkg::binIdx_t   evBin,
    output logic                   acquiring,
    output logic                   acqBusy,
    output logic                   wrEn,
    output histDataPkg::binIdx_t   wrAddr,
    output histDataPkg::binCount_t wrData,
    output histDataPkg::binIdx_t   rdAddrA,
    input  histDataPkg::binCount_t rdDataA,
    output logic                   sweepStart,
    input  logic                   sweepDone
);

    histCtrlPkg::accState_t state;
    histDataPkg::binIdx_t   clrAddr;
    histDataPkg::evCount_t  evCnt;
    logic                   lastEvent;
    logic                   clearing;

    // stage 1 waits for the RAM read, stage 2 writes
    logic                   s1Valid;
    histDataPkg::binIdx_t   s1Bin;
    logic                   s2Valid;
    histDataPkg::binIdx_t   s2Bin;
    histDataPkg::binCount_t s2Count;

    // write that landed on the same edge as the stage 1 read
    logic                   wbValid;
    histDataPkg::binIdx_t   wbBin;
    histDataPkg::binCount_t wbCount;

    histDataPkg::binCount_t baseCount;
    histDataPkg::binCount_t nextCount;

    assign lastEvent = evValid && (evCnt == histDataPkg::evCount_t'(`ACQ_EVENTS - 1));
    assign clearing  = state == histCtrlPkg::ACC_CLEAR;
    assign acqBusy   = state != histCtrlPkg::ACC_IDLE;

    // drop at once on the final event so no further code gets through
    assign acquiring = (state == histCtrlPkg::ACC_RUN) && !lastEvent;

    assign rdAddrA = evBin;

    assign wrEn   = clearing || s2Valid;
    assign wrAddr = clearing ? clrAddr : s2Bin;
    assign wrData = clearing ? '0 : s2Count;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state      <= histCtrlPkg::ACC_IDLE;
            clrAddr    <= '0;
            evCnt      <= '0;
            sweepStart <= 1'b0;
        end else begin
            sweepStart <= 1'b0;
            case (state)
                histCtrlPkg::ACC_IDLE: begin
                    if (acqStart) begin
                        state   <= histCtrlPkg::ACC_CLEAR;
                        clrAddr <= '0;
                        evCnt   <= '0;
                    end
                end
                histCtrlPkg::ACC_CLEAR: begin
                    clrAddr <= clrAddr + 1'b1;
                    if (clrAddr == '1) begin
                        state <= histCtrlPkg::ACC_RUN;
                    end
                end
                histCtrlPkg::ACC_RUN: begin
                    if (evValid) begin
                        evCnt <= evCnt + 1'b1;
                        if (lastEvent) begin
                            state <= histCtrlPkg::ACC_DRAIN;
                        end
                    end
                end
                histCtrlPkg::ACC_DRAIN: begin
                    if (!s1Valid && !s2Valid) begin // last write has landed
                        sweepStart <= 1'b1;
                        state      <= histCtrlPkg::ACC_READOUT;
                    end
                end
                histCtrlPkg::ACC_READOUT: begin
                    if (sweepDone) begin
                        state <= histCtrlPkg::ACC_IDLE;
                    end
                end
                default: state <= histCtrlPkg::ACC_IDLE;
            endcase
        end
    end

    // newest in-flight value wins over the RAM
    always_comb begin
        if (s2Valid && (s2Bin == s1Bin)) begin
            baseCount = s2Count;
        end else if (wbValid && (wbBin == s1Bin)) begin
            baseCount = wbCount;
        end else begin
            baseCount = rdDataA;
        end
        nextCount = (baseCount == '1) ? baseCount : baseCount + 1'b1; // saturate
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            wbValid <= 1'b0;
        end else begin
            s1Valid <= evValid;
            s2Valid <= s1Valid;
            wbValid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin   <= evBin;
        s2Bin   <= s1Bin;
        s2Count <= nextCount;
        wbBin   <= s2Bin;
        wbCount <= s2Count;
    end

    aNoWriteIdle: assert property (@(posedge clk) disable iff (!res)
        state == histCtrlPkg::ACC_IDLE |-> !wrEn);

    aAcqInRun: assert property (@(posedge clk) disable iff (!res)
        acquiring |-> (state == histCtrlPkg::ACC_RUN)
            && (evCnt < histDataPkg::evCount_t'(`ACQ_EVENTS)));

endmodule

// ==== hw/peakReadout.sv ====
`timescale 1ns/1ps

module peakReadout (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   sweepStart,
    output logic                   rdEnB,
    output histDataPkg::binIdx_t   rdAddrB,
    input  histDataPkg::binCount_t rdDataB,
    output logic                   binValid,
    output histDataPkg::binIdx_t   binIndex,
    output histDataPkg::binCount_t binCount,
    output logic                   peakValid,
    output histDataPkg::binIdx_t   peakBin,
    output histDataPkg::binCount_t peakCount,
    output logic                   sweepDone
);

    histCtrlPkg::rdState_t state;
    logic                  takeMax;

    assign rdEnB    = state == histCtrlPkg::RD_SWEEP;
    assign binCount = rdDataB; // RAM output lines up with binIndex

    // bin 0 restarts the search, ties keep the lower index
    assign takeMax = binValid && ((binIndex == '0) || (rdDataB > peakCount));

    assign sweepDone = peakValid; // peak report closes the sweep

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= histCtrlPkg::RD_IDLE;
            rdAddrB   <= '0;
            binValid  <= 1'b0;
            peakValid <= 1'b0;
        end else begin
            binValid  <= rdEnB;
            peakValid <= 1'b0;
            case (state)
                histCtrlPkg::RD_IDLE: begin
                    rdAddrB <= '0;
                    if (sweepStart) begin
                        state <= histCtrlPkg::RD_SWEEP;
                    end
                end
                histCtrlPkg::RD_SWEEP: begin
                    rdAddrB <= rdAddrB + 1'b1;
                    if (rdAddrB == '1) begin
                        state <= histCtrlPkg::RD_PEAK;
                    end
                end
                histCtrlPkg::RD_PEAK: begin
                    // last bin is on the outputs now
                    peakValid <= 1'b1;
                    state     <= histCtrlPkg::RD_IDLE;
                end
                default: state <= histCtrlPkg::RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdEnB) begin
            binIndex <= rdAddrB; // delayed to match read latency
        end
        if (takeMax) begin
            peakBin   <= binIndex;
            peakCount <= rdDataB;
        end
    end

    aBinOrder: assert property (@(posedge clk) disable iff (!res)
        binValid && $past(binValid)
            |-> binIndex == histDataPkg::binIdx_t'($past(binIndex) + 1'b1));

endmodule

// ==== hw/sifhHist.sv ====
`timescale 1ns/1ps

module sifhHist (
    input  logic                   clk,
    input  logic                   res,
    input  logic                   acqStart,
    input  logic                   dataValid,
    input  histDataPkg::timeCode_t data,
    output logic                   acqBusy,
    output histDataPkg::evCount_t  rejectCount,
    output logic                   binValid,
    output histDataPkg::binIdx_t   binIndex,
    output histDataPkg::binCount_t binCount,
    output logic                   peakValid,
    output histDataPkg::binIdx_t   peakBin,
    output histDataPkg::binCount_t peakCount
);

    logic                   evValid;
    histDataPkg::binIdx_t   evBin;
    logic                   acquiring;
    logic                   wrEn;
    histDataPkg::binIdx_t   wrAddr;
    histDataPkg::binCount_t wrData;
    histDataPkg::binIdx_t   rdAddrA;
    histDataPkg::binCount_t rdDataA;
    logic                   rdEnB;
    histDataPkg::binIdx_t   rdAddrB;
    histDataPkg::binCount_t rdDataB;
    logic                   sweepStart;
    logic                   sweepDone;

    photonCapture photonCapture_i (
        .clk        (clk),
        .res        (res),
        .acquiring  (acquiring),
        .dataValid  (dataValid),
        .data       (data),
        .evValid    (evValid),
        .evBin      (evBin),
        .rejectCount(rejectCount),
        .acqStart   (acqStart)
    );

    histAccumulator histAccumulator_i (
        .clk       (clk),
        .res       (res),
        .acqStart  (acqStart),
        .evValid   (evValid),
        .evBin     (evBin),
        .acquiring (acquiring),
        .acqBusy   (acqBusy),
        .wrEn      (wrEn),
        .wrAddr    (wrAddr),
        .wrData    (wrData),
        .rdAddrA   (rdAddrA),
        .rdDataA   (rdDataA),
        .sweepStart(sweepStart),
        .sweepDone (sweepDone)
    );

    histRam histRam_i (
        .clk    (clk),
        .wrEn   (wrEn),
        .wrAddr (wrAddr),
        .wrData (wrData),
        .rdAddrA(rdAddrA),
        .rdDataA(rdDataA),
        .rdEnB  (rdEnB),
        .rdAddrB(rdAddrB),
        .rdDataB(rdDataB)
    );

    peakReadout peakReadout_i (
        .clk       (clk),
        .res       (res),
        .sweepStart(sweepStart),
        .rdEnB     (rdEnB),
        .rdAddrB   (rdAddrB),
        .rdDataB   (rdDataB),
        .binValid  (binValid),
        .binIndex  (binIndex),
        .binCount  (binCount),
        .peakValid (peakValid),
        .peakBin   (peakBin),
        .peakCount (peakCount),
        .sweepDone (sweepDone)
    );

endmodule

// ==== tests/sifhHist_tb.sv ====
`timescale 1ns/1ps
`include "sifhHist_macros.svh"

module sifhHist_tb;

    localparam int NBINS = 1 << `NB;
    localparam int CYCLE_LIMIT = 5000; // three runs of about 350 cycles, readout, margin

    logic                   clk;
    logic                   res;
    logic                   acqStart;
    logic                   dataValid;
    histDataPkg::timeCode_t data;
    logic                   acqBusy;
    histDataPkg::evCount_t  rejectCount;
    logic                   binValid;
    histDataPkg::binIdx_t   binIndex;
    histDataPkg::binCount_t binCount;
    logic                   peakValid;
    histDataPkg::binIdx_t   peakBin;
    histDataPkg::binCount_t peakCount;

    histDataPkg::binCount_t modelHist [0:NBINS-1];
    histDataPkg::evCount_t  modelRejects;
    int                     accepted;
    int                     binsSeen;
    logic                   peakSeen;
    int                     runsChecked;
    int                     cycleCount;
    integer                 seed;

    sifhHist sifhHist_i (
        .clk        (clk),
        .res        (res),
        .acqStart   (acqStart),
        .dataValid  (dataValid),
        .data       (data),
        .acqBusy    (acqBusy),
        .rejectCount(rejectCount),
        .binValid   (binValid),
        .binIndex   (binIndex),
        .binCount   (binCount),
        .peakValid  (peakValid),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

    always #2 clk = ~clk;

    task automatic reportMismatch(input string msg);
        $display("MISMATCH at %0d ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "value check failed");
    endtask

    task automatic abortRun(input string msg);
        $display("ERROR at %0d ns: %s", $time, msg);
        $display("SOME TESTS FAILED");
        $fatal(1, "test aborted");
    endtask

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            abortRun($sformatf("timeout, run not finished after %0d cycles", CYCLE_LIMIT));
        end
    end

    // bin is the top bits of the code, counts stop at all ones
    function automatic void modelEvent(input histDataPkg::timeCode_t code);
        histDataPkg::binIdx_t b;
        b = code[`NP-1 -: `NB];
        if (code < histDataPkg::timeCode_t'(`TIME_WINDOW)) begin
            accepted++;
            if (modelHist[b] != '1) begin
                modelHist[b] = modelHist[b] + histDataPkg::binCount_t'(1);
            end
        end else begin
            modelRejects = modelRejects + histDataPkg::evCount_t'(1);
        end
    endfunction

    // lowest index wins a tie
    function automatic histDataPkg::binIdx_t expectedPeak();
        histDataPkg::binIdx_t best;
        best = '0;
        for (int i = 1; i < NBINS; i++) begin
            if (modelHist[i] > modelHist[best]) begin
                best = histDataPkg::binIdx_t'(i);
            end
        end
        return best;
    endfunction

    task automatic checkBin(input histDataPkg::binIdx_t idx, input histDataPkg::binCount_t cnt);
        histDataPkg::binIdx_t expIdx;
        expIdx = histDataPkg::binIdx_t'(binsSeen);
        if (binsSeen >= NBINS) begin
            abortRun("more than 16 bins streamed in one readout");
        end
        if (idx !== expIdx) begin
            reportMismatch($sformatf("bin index %0d, expected %0d", idx, expIdx));
        end
        if (cnt !== modelHist[expIdx]) begin
            reportMismatch($sformatf("bin %0d count %0d, expected %0d",
                expIdx, cnt, modelHist[expIdx]));
        end
        binsSeen++;
    endtask

    task automatic checkPeak(input histDataPkg::binIdx_t bin, input histDataPkg::binCount_t cnt,
                             input histDataPkg::evCount_t rejects);
        histDataPkg::binIdx_t expBin;
        expBin = expectedPeak();
        if (bin !== expBin || cnt !== modelHist[expBin]) begin
            reportMismatch($sformatf("peak bin %0d count %0d, expected bin %0d count %0d",
                bin, cnt, expBin, modelHist[expBin]));
        end
        if (rejects !== modelRejects) begin
            reportMismatch($sformatf("rejectCount %0d, expected %0d", rejects, modelRejects));
        end
    endtask

    // outputs only change on the rising edge
    always @(negedge clk) begin
        if (binValid) begin
            checkBin(binIndex, binCount);
        end
        if (peakValid) begin
            if (binsSeen != NBINS) begin
                abortRun("peak reported before all 16 bins were streamed");
            end
            checkPeak(peakBin, peakCount, rejectCount);
            peakSeen = 1'b1;
        end
    end

    task automatic sendCode(input histDataPkg::timeCode_t code);
        dataValid = 1'b1;
        data      = code;
        modelEvent(code);
        @(negedge clk);
        dataValid = 1'b0;
    endtask

    task automatic sendBurst(input histDataPkg::timeCode_t code, input int len);
        for (int i = 0; i < len; i++) begin
            sendCode(code); // same bin on consecutive cycles
        end
    endtask

    function automatic histDataPkg::timeCode_t codeInBin(input histDataPkg::binIdx_t b);
        logic [31:0] r;
        r = $random(seed);
        return {b, r[`NP-`NB-1:0]};
    endfunction

    // in-window codes with gaps and out-of-window codes mixed in
    task automatic randomTraffic(input int target);
        logic [31:0] r;
        while (accepted < target) begin
            r = $random(seed);
            if (r[2:0] == 3'd0) begin
                sendCode(histDataPkg::timeCode_t'(`TIME_WINDOW + r[15:8] % 224));
            end else if (r[4:3] == 2'd0) begin
                @(negedge clk); // idle cycle
            end else begin
                sendCode(histDataPkg::timeCode_t'(r[31:16] % `TIME_WINDOW));
            end
        end
    endtask

    task automatic startRun();
        acqStart = 1'b1;
        @(negedge clk);
        acqStart = 1'b0;
        for (int i = 0; i < NBINS; i++) begin
            modelHist[i] = '0;
        end
        modelRejects = '0;
        accepted     = 0;
        binsSeen     = 0;
        peakSeen     = 1'b0;
        repeat (17) @(negedge clk); // clear sweep of 16 bins
    endtask

    task automatic finishRun();
        while (acqBusy) begin
            @(negedge clk);
        end
        if (binsSeen != NBINS) begin
            abortRun("readout missing or incomplete when acqBusy fell");
        end
        if (!peakSeen) begin
            abortRun("no peak report when acqBusy fell");
        end
        runsChecked++;
        @(negedge clk);
    endtask

    initial begin
        logic [31:0] r;
        seed        = 32'hfb6c;
        cycleCount  = 0;
        runsChecked = 0;
        binsSeen    = 0;
        peakSeen    = 1'b0;
        clk         = 1'b0;
        res         = 1'b0;
        acqStart    = 1'b0;
        dataValid   = 1'b0;
        data        = '0;
        repeat (2) @(negedge clk);
        res = 1'b1;
        if (acqBusy !== 1'b0 || binValid !== 1'b0 || peakValid !== 1'b0
                || rejectCount !== '0) begin
            reportMismatch("outputs not idle after reset");
        end

        // random traffic, a start pulse mid-run, then bursts
        startRun();
        randomTraffic(150);
        acqStart = 1'b1; // must be ignored while busy
        sendCode(codeInBin(histDataPkg::binIdx_t'(3)));
        acqStart = 1'b0;
        randomTraffic(200);
        for (int j = 0; j < 10; j++) begin
            r = $random(seed);
            sendBurst(codeInBin(histDataPkg::binIdx_t'(r[7:0] % 12)), 10);
        end
        finishRun();

        // bin 7 past saturation
        startRun();
        randomTraffic(15);
        sendBurst(codeInBin(histDataPkg::binIdx_t'(7)), 270);
        randomTraffic(`ACQ_EVENTS);
        finishRun();

        // fresh bins, tie between 4 and 9
        startRun();
        for (int j = 0; j < 60; j++) begin
            sendCode(codeInBin(histDataPkg::binIdx_t'(j % 4)));
        end
        for (int j = 0; j < 120; j++) begin
            sendCode(codeInBin(histDataPkg::binIdx_t'(9)));
            sendCode(codeInBin(histDataPkg::binIdx_t'(4)));
        end
        finishRun();

        if (runsChecked == 3) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "not every run was checked");
        end
    end

endmodule

// ==== sifhHist.f ====
+incdir+hw
hw/histDataPkg.sv
hw/histCtrlPkg.sv
hw/photonCapture.sv
hw/histRam.sv
hw/histAccumulator.sv
hw/peakReadout.sv
hw/sifhHist.sv
tests/sifhHist_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build the sifhHist testbench with Verilator and run it
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module sifhHist_tb \
    -f sifhHist.f \
    -o sifhHist_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/sifhHist_sim
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

echo "simulation finished with status 0"
exit 0
